//--- dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address and data path
`define DC_ADDR_W     32
`define DC_DATA_W     32

// cache geometry
`define DC_WAYS       4
`define DC_WAY_W      2
`define DC_SETS       64
`define DC_INDEX_W    6

// line layout, four words per line
`define DC_LINE_WORDS 4
`define DC_OFFSET_W   2
`define DC_LINE_W     128

// what is left of the address above index and offsets
`define DC_TAG_W      22

`endif

//--- dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

    // field view of a byte address
    typedef struct packed {
        logic [`DC_TAG_W-1:0]    tag;
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_OFFSET_W-1:0] word;
        logic [1:0]              byte_sel;
    } dc_addr_fields_t;

    // flat word on the LSU and memory side, fields inside the cache
    typedef union packed {
        logic [`DC_ADDR_W-1:0] flat;
        dc_addr_fields_t       f;
    } dc_addr_t;

    // controller states, burst kinds reuse writeback and refill
    typedef enum logic [2:0] {
        s_idle      = 3'd0,
        s_lookup    = 3'd1,
        s_writeback = 3'd2,
        s_refill    = 3'd3,
        s_respond   = 3'd4,
        s_fill      = 3'd5
    } dc_state_t;

endpackage

//--- lsu_port.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module lsu_port import dcache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    req_write,
    input  logic [`DC_ADDR_W-1:0]   req_addr,
    input  logic [`DC_DATA_W-1:0]   req_wdata,
    input  logic [`DC_DATA_W/8-1:0] req_wstrb,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic [`DC_DATA_W-1:0]   rsp_rdata,
    output logic                    start,
    output dc_addr_t                hold_addr,
    output logic                    hold_write,
    output logic [`DC_DATA_W-1:0]   hold_wdata,
    output logic [`DC_DATA_W/8-1:0] hold_wstrb,
    input  logic                    finish,
    input  logic [`DC_LINE_W-1:0]   rsp_line
);

    logic accept;
    logic rsp_done;

    assign accept   = req_valid && req_ready;
    assign rsp_done = rsp_valid && rsp_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_ready <= 1'b1;
            start     <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            start <= accept;
            // ready comes back only once the response has gone out
            if (accept) begin
                req_ready <= 1'b0;
            end else if (rsp_done) begin
                req_ready <= 1'b1;
            end
            if (finish) begin
                rsp_valid <= 1'b1;
            end else if (rsp_done) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_addr.flat <= req_addr;
            hold_write     <= req_write;
            hold_wdata     <= req_wdata;
            hold_wstrb     <= req_wstrb;
        end
        // pick the addressed word out of the final line
        if (finish) begin
            rsp_rdata <= rsp_line[hold_addr.f.word*`DC_DATA_W +: `DC_DATA_W];
        end
    end

    // the controller finishes only the request it was handed
    assert property (@(posedge clk) disable iff (!rst_n)
        finish |-> !req_ready && !rsp_valid)
        else $error("finish with no request outstanding");

endmodule

//--- tag_array.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module tag_array (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`DC_INDEX_W-1:0] index,
    input  logic [`DC_TAG_W-1:0]   tag,
    input  logic                   update,
    input  logic [`DC_WAY_W-1:0]   update_way,
    input  logic                   update_dirty,
    output logic                   hit,
    output logic [`DC_WAY_W-1:0]   hit_way,
    output logic [`DC_WAY_W-1:0]   victim_way,
    output logic                   victim_dirty,
    output logic [`DC_TAG_W-1:0]   victim_tag
);

    logic [`DC_WAYS-1:0]  valid_q [`DC_SETS];
    logic [`DC_WAYS-1:0]  dirty_q [`DC_SETS];
    logic [`DC_TAG_W-1:0] tag_q   [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0]  way_hit;
    logic [7:0]           lfsr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (update) begin
            valid_q[index][update_way] <= 1'b1;
            dirty_q[index][update_way] <= update_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            tag_q[index][update_way] <= tag;
        end
    end

    // free-running 8-bit LFSR, taps 8 6 5 4
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= 8'h01;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    // compare all ways of the set in parallel
    always_comb begin
        way_hit = '0;
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = valid_q[index][w] && (tag_q[index][w] == tag);
            if (way_hit[w]) begin
                hit_way = w[`DC_WAY_W-1:0];
            end
        end
    end

    assign hit          = |way_hit;
    assign victim_way   = lfsr_q[`DC_WAY_W-1:0];
    assign victim_dirty = valid_q[index][victim_way] && dirty_q[index][victim_way];
    assign victim_tag   = tag_q[index][victim_way];

    // a refill never installs a tag that is already present in the set
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(way_hit))
        else $error("more than one way hits in set %0d", index);

endmodule

//--- data_array.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module data_array (
    input  logic                    clk,
    input  logic [`DC_WAY_W-1:0]    way,
    input  logic [`DC_INDEX_W-1:0]  index,
    input  logic                    write,
    input  logic [`DC_LINE_W/8-1:0] byte_en,
    input  logic [`DC_LINE_W-1:0]   wline,
    output logic [`DC_LINE_W-1:0]   rline
);

    logic [`DC_LINE_W-1:0]            mem [`DC_WAYS*`DC_SETS];
    logic [`DC_WAY_W+`DC_INDEX_W-1:0] addr;

    // way in the upper bits, set in the lower
    assign addr = {way, index};

    // written bytes show up on the read port in the same cycle
    always_ff @(posedge clk) begin
        for (int b = 0; b < `DC_LINE_W/8; b++) begin
            if (write && byte_en[b]) begin
                mem[addr][b*8 +: 8] <= wline[b*8 +: 8];
                rline[b*8 +: 8]     <= wline[b*8 +: 8];
            end else begin
                rline[b*8 +: 8] <= mem[addr][b*8 +: 8];
            end
        end
    end

endmodule

//--- cache_ctrl.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module cache_ctrl import dcache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  dc_addr_t                hold_addr,
    input  logic                    hold_write,
    input  logic [`DC_DATA_W-1:0]   hold_wdata,
    input  logic [`DC_DATA_W/8-1:0] hold_wstrb,
    output logic                    finish,
    output logic [`DC_LINE_W-1:0]   rsp_line,
    output logic [`DC_INDEX_W-1:0]  index,
    output logic [`DC_TAG_W-1:0]    tag,
    output logic                    update,
    output logic [`DC_WAY_W-1:0]    update_way,
    output logic                    update_dirty,
    input  logic                    hit,
    input  logic [`DC_WAY_W-1:0]    hit_way,
    input  logic [`DC_WAY_W-1:0]    victim_way,
    input  logic                    victim_dirty,
    input  logic [`DC_TAG_W-1:0]    victim_tag,
    output logic [`DC_WAY_W-1:0]    way,
    output logic                    write,
    output logic [`DC_LINE_W/8-1:0] byte_en,
    output logic [`DC_LINE_W-1:0]   wline,
    input  logic [`DC_LINE_W-1:0]   rline,
    output logic                    refill_start,
    output logic                    writeback_start,
    output logic [`DC_ADDR_W-1:0]   line_addr,
    output logic [`DC_LINE_W-1:0]   wb_line,
    input  logic                    burst_done,
    input  logic [`DC_LINE_W-1:0]   refill_line
);

    dc_state_t               state_q;
    logic [`DC_WAY_W-1:0]    way_q;
    logic [`DC_TAG_W-1:0]    victim_tag_q;
    logic [`DC_LINE_W/8-1:0] store_be;
    logic [`DC_LINE_W-1:0]   store_line;
    logic [`DC_LINE_W-1:0]   merged_line;
    dc_addr_t                line_base;

    // store strobes moved to the word offset within the line
    always_comb begin
        store_be = '0;
        if (hold_write) begin
            store_be[hold_addr.f.word*(`DC_DATA_W/8) +: `DC_DATA_W/8] = hold_wstrb;
        end
    end

    assign store_line = {`DC_LINE_WORDS{hold_wdata}};

    // refilled line with the pending store laid over it
    always_comb begin
        for (int b = 0; b < `DC_LINE_W/8; b++) begin
            merged_line[b*8 +: 8] = store_be[b] ? store_line[b*8 +: 8] : refill_line[b*8 +: 8];
        end
    end

    assign index = hold_addr.f.index;
    assign tag   = hold_addr.f.tag;

    // lookup reads the hit way, or the candidate victim on a miss
    assign way     = (state_q == s_lookup) ? (hit ? hit_way : victim_way) : way_q;
    assign write   = ((state_q == s_lookup) && hit && hold_write) || (state_q == s_fill);
    assign byte_en = (state_q == s_fill) ? '1 : store_be;
    assign wline   = (state_q == s_fill) ? merged_line : store_line;

    assign update       = write;
    assign update_way   = way;
    assign update_dirty = hold_write;

    assign finish   = (state_q == s_respond);
    assign rsp_line = rline;
    assign wb_line  = rline;

    // write-back goes to the victim's own address
    always_comb begin
        line_base            = hold_addr;
        line_base.f.word     = '0;
        line_base.f.byte_sel = '0;
        if (state_q == s_writeback) begin
            line_base.f.tag = victim_tag_q;
        end
    end

    assign line_addr = line_base.flat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q         <= s_idle;
            refill_start    <= 1'b0;
            writeback_start <= 1'b0;
        end else begin
            refill_start    <= 1'b0;
            writeback_start <= 1'b0;
            case (state_q)
                s_idle: begin
                    if (start) begin
                        state_q <= s_lookup;
                    end
                end
                s_lookup: begin
                    if (hit) begin
                        state_q <= s_respond;
                    end else if (victim_dirty) begin
                        state_q         <= s_writeback;
                        writeback_start <= 1'b1;
                    end else begin
                        state_q      <= s_refill;
                        refill_start <= 1'b1;
                    end
                end
                s_writeback: begin
                    if (burst_done) begin
                        state_q      <= s_refill;
                        refill_start <= 1'b1;
                    end
                end
                s_refill: begin
                    if (burst_done) begin
                        state_q <= s_fill;
                    end
                end
                s_fill:    state_q <= s_respond;
                s_respond: state_q <= s_idle;
                default:   state_q <= s_idle;
            endcase
        end
    end

    // victim choice frozen for the rest of the miss
    always_ff @(posedge clk) begin
        if (state_q == s_lookup) begin
            way_q        <= way;
            victim_tag_q <= victim_tag;
        end
    end

endmodule

//--- mem_burst.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module mem_burst import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  refill_start,
    input  logic                  writeback_start,
    input  logic [`DC_ADDR_W-1:0] line_addr,
    input  logic [`DC_LINE_W-1:0] wb_line,
    output logic                  burst_done,
    output logic [`DC_LINE_W-1:0] refill_line,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output logic                  mem_write,
    output logic [`DC_ADDR_W-1:0] mem_addr,
    output logic [`DC_DATA_W-1:0] mem_wdata,
    input  logic                  mem_rsp_valid,
    input  logic [`DC_DATA_W-1:0] mem_rdata
);

    dc_state_t               mode_q;
    logic [`DC_OFFSET_W-1:0] beat_q;
    logic                    wait_q;
    logic                    req_fire;
    logic                    rd_beat;
    logic                    beat_done;
    logic                    last_beat;

    // read requests pause until their data has come back
    assign mem_req_valid = (mode_q != s_idle) && !wait_q;
    assign mem_write     = (mode_q == s_writeback);
    assign mem_addr      = {line_addr[`DC_ADDR_W-1:`DC_OFFSET_W+2], beat_q, 2'b00};
    assign mem_wdata     = wb_line[beat_q*`DC_DATA_W +: `DC_DATA_W];

    assign req_fire  = mem_req_valid && mem_req_ready;
    assign rd_beat   = (mode_q == s_refill) && mem_rsp_valid;
    // a write beat ends at its handshake, a read beat at its data
    assign beat_done = (mem_write && req_fire) || rd_beat;
    assign last_beat = (beat_q == (`DC_LINE_WORDS-1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q     <= s_idle;
            beat_q     <= '0;
            wait_q     <= 1'b0;
            burst_done <= 1'b0;
        end else begin
            burst_done <= 1'b0;
            if (writeback_start || refill_start) begin
                mode_q <= writeback_start ? s_writeback : s_refill;
                beat_q <= '0;
                wait_q <= 1'b0;
            end else if (beat_done) begin
                beat_q <= beat_q + 1'b1;
                wait_q <= 1'b0;
                if (last_beat) begin
                    mode_q     <= s_idle;
                    burst_done <= 1'b1;
                end
            end else if (req_fire) begin
                wait_q <= 1'b1;
            end
        end
    end

    // beat 0 ends up in the low word after four shifts
    always_ff @(posedge clk) begin
        if (rd_beat) begin
            refill_line <= {mem_rdata, refill_line[`DC_LINE_W-1:`DC_DATA_W]};
        end
    end

    // the line address from the controller holds through a stalled beat
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_addr) && $stable(mem_write))
        else $error("memory request changed while stalled in %s burst", mode_q.name());

endmodule

//--- dcache_top.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    req_write,
    input  logic [`DC_ADDR_W-1:0]   req_addr,
    input  logic [`DC_DATA_W-1:0]   req_wdata,
    input  logic [`DC_DATA_W/8-1:0] req_wstrb,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic [`DC_DATA_W-1:0]   rsp_rdata,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output logic                    mem_write,
    output logic [`DC_ADDR_W-1:0]   mem_addr,
    output logic [`DC_DATA_W-1:0]   mem_wdata,
    input  logic                    mem_rsp_valid,
    input  logic [`DC_DATA_W-1:0]   mem_rdata
);

    // request hand-off between LSU port and controller
    logic                    start;
    dc_addr_t                hold_addr;
    logic                    hold_write;
    logic [`DC_DATA_W-1:0]   hold_wdata;
    logic [`DC_DATA_W/8-1:0] hold_wstrb;
    logic                    finish;
    logic [`DC_LINE_W-1:0]   rsp_line;

    // tag array
    logic [`DC_INDEX_W-1:0]  index;
    logic [`DC_TAG_W-1:0]    tag;
    logic                    update;
    logic [`DC_WAY_W-1:0]    update_way;
    logic                    update_dirty;
    logic                    hit;
    logic [`DC_WAY_W-1:0]    hit_way;
    logic [`DC_WAY_W-1:0]    victim_way;
    logic                    victim_dirty;
    logic [`DC_TAG_W-1:0]    victim_tag;

    // data array
    logic [`DC_WAY_W-1:0]    way;
    logic                    write;
    logic [`DC_LINE_W/8-1:0] byte_en;
    logic [`DC_LINE_W-1:0]   wline;
    logic [`DC_LINE_W-1:0]   rline;

    // burst sequencer
    logic                    refill_start;
    logic                    writeback_start;
    logic [`DC_ADDR_W-1:0]   line_addr;
    logic [`DC_LINE_W-1:0]   wb_line;
    logic                    burst_done;
    logic [`DC_LINE_W-1:0]   refill_line;

    lsu_port   u_lsu_port   (.*);
    tag_array  u_tag_array  (.*);
    data_array u_data_array (.*);
    cache_ctrl u_cache_ctrl (.*);
    mem_burst  u_mem_burst  (.*);

endmodule

//--- tb_mem_model.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module tb_mem_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_req_valid,
    output logic                  mem_req_ready,
    input  logic                  mem_write,
    input  logic [`DC_ADDR_W-1:0] mem_addr,
    input  logic [`DC_DATA_W-1:0] mem_wdata,
    output logic                  mem_rsp_valid,
    output logic [`DC_DATA_W-1:0] mem_rdata,
    output logic [`DC_DATA_W-1:0] cur_word
);

    localparam int MEM_BYTES = 65536;

    logic [7:0]            shadow [MEM_BYTES];
    logic [`DC_ADDR_W-1:0] rd_addr;
    logic [`DC_ADDR_W-1:0] wr_addr;
    logic [`DC_DATA_W-1:0] wr_data;
    logic                  wr_pending;
    int                    rd_wait;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [15:0] a;
        a = {addr[15:2], 2'b00};
        return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            shadow[{addr[15:2], 2'b00} + b] = data[b*8 +: 8];
        end
    endtask

    // word under the current memory address, before any write at this edge
    always_comb begin
        cur_word = {shadow[{mem_addr[15:2], 2'b11}], shadow[{mem_addr[15:2], 2'b10}],
                    shadow[{mem_addr[15:2], 2'b01}], shadow[{mem_addr[15:2], 2'b00}]};
    end

    // word address xor a constant
    initial begin
        for (int w = 0; w < MEM_BYTES / 4; w++) begin
            write_word(w << 2, w ^ 32'h5a3c_96e1);
        end
    end

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rdata     = '0;
        wr_pending    = 1'b0;
        rd_wait       = 0;
        forever begin
            @(posedge clk);
            #10;
            mem_rsp_valid = 1'b0;
            if (wr_pending) begin
                write_word(wr_addr, wr_data);
                wr_pending = 1'b0;
            end
            if (rd_wait > 0) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rdata     = read_word(rd_addr);
                end
            end
            // stall about one cycle in three
            mem_req_ready = rst_n && ($urandom_range(0, 2) != 0);
            if (mem_req_valid && mem_req_ready) begin
                if (mem_write) begin
                    wr_pending = 1'b1;
                    wr_addr    = mem_addr;
                    wr_data    = mem_wdata;
                end else begin
                    rd_addr = mem_addr;
                    rd_wait = 1 + $urandom_range(0, 2);
                end
            end
        end
    end

endmodule

//--- tb_dcache.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module tb_dcache;

    localparam int TIMEOUT_CYCLES = 20000;

    logic                    clk;
    logic                    rst_n;
    logic                    req_valid;
    logic                    req_ready;
    logic                    req_write;
    logic [`DC_ADDR_W-1:0]   req_addr;
    logic [`DC_DATA_W-1:0]   req_wdata;
    logic [`DC_DATA_W/8-1:0] req_wstrb;
    logic                    rsp_valid;
    logic                    rsp_ready;
    logic [`DC_DATA_W-1:0]   rsp_rdata;
    logic                    mem_req_valid;
    logic                    mem_req_ready;
    logic                    mem_write;
    logic [`DC_ADDR_W-1:0]   mem_addr;
    logic [`DC_DATA_W-1:0]   mem_wdata;
    logic                    mem_rsp_valid;
    logic [`DC_DATA_W-1:0]   mem_rdata;
    logic [`DC_DATA_W-1:0]   cur_word;

    // reference view of the request in flight
    logic [`DC_ADDR_W-1:0]   cur_addr;
    logic [`DC_DATA_W-1:0]   exp_rdata;
    logic                    expect_hit;
    logic                    expect_miss;
    logic [3:0]              rd_beats;
    logic [3:0]              wb_beats;
    logic                    accept;
    logic                    rd_fire;
    logic                    wb_fire;
    int                      err_count = 0;
    int                      cycles = 0;

    // lines whose latest store has not reached memory yet
    bit                      stale_line [4096];
    int                      wb_bursts = 0;

    dcache_top u_dut (.*);
    tb_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    assign accept  = req_valid && req_ready;
    assign rd_fire = mem_req_valid && mem_req_ready && !mem_write;
    assign wb_fire = mem_req_valid && mem_req_ready && mem_write;

    // memory beats seen since the last accepted request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_beats <= '0;
            wb_beats <= '0;
        end else if (accept) begin
            rd_beats <= '0;
            wb_beats <= '0;
        end else begin
            if (rd_fire) begin
                rd_beats <= rd_beats + 1'b1;
            end
            if (wb_fire) begin
                wb_beats <= wb_beats + 1'b1;
            end
        end
    end

    // last write-back beat brings memory up to date for that line
    always @(posedge clk) begin
        if (rst_n && wb_fire && wb_beats == 3) begin
            stale_line[mem_addr[15:4]] = 1'b0;
            wb_bursts++;
        end
    end

    function automatic void log_error(input string msg);
        err_count++;
        $display("** Error at %0t ns: %s", $time, msg);
    endfunction

    assert property (@(posedge clk) $rose(rst_n) |-> req_ready && !rsp_valid && !mem_req_valid)
        else log_error("outputs not idle after reset");
    assert property (@(posedge clk) disable iff (!rst_n)
        accept && expect_hit |=> !rsp_valid [*3] ##1 rsp_valid)
        else log_error("hit response not 3 cycles after acceptance");
    assert property (@(posedge clk) disable iff (!rst_n) expect_hit |-> !mem_req_valid)
        else log_error("memory traffic on a cache hit");
    // refill beats walk the requested line in order
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_fire |-> mem_addr == {cur_addr[31:4], rd_beats[1:0], 2'b00})
        else log_error($sformatf("refill address %h, beat %0d", mem_addr, rd_beats));
    // a dirty line must have gone back to memory before it is fetched again
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_fire |-> !stale_line[mem_addr[15:4]])
        else log_error($sformatf("refill of line %h before its store was written back",
                                 mem_addr));
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_fire |-> mem_addr[3:2] == wb_beats[1:0] && mem_wdata == cur_word)
        else log_error($sformatf("write-back %h at %h, expected %h", mem_wdata, mem_addr,
                                 cur_word));
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp_valid) |-> (rd_beats == 4 || (!expect_miss && rd_beats == 0))
                             && (wb_beats == 0 || wb_beats == 4))
        else log_error($sformatf("burst counts rd %0d wb %0d", rd_beats, wb_beats));
    assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> rsp_rdata == exp_rdata)
        else log_error($sformatf("rsp_rdata %h, expected %h", rsp_rdata, exp_rdata));
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
        else log_error("response dropped or changed under back-pressure");
    assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> !req_ready)
        else log_error("new request possible before response transfer");
    assert property (@(posedge clk) disable iff (!rst_n) mem_req_valid |-> mem_addr[31:16] == '0)
        else log_error($sformatf("memory address %h outside the model", mem_addr));

    // one full request and response, called 10 ns after a rising edge
    task automatic issue_request(input logic wr, input logic [31:0] addr,
                                 input logic hit, input logic miss);
        logic [31:0] data;
        logic [3:0]  strb;
        data        = $urandom();
        strb        = wr ? 4'($urandom_range(1, 15)) : 4'h0;
        cur_addr    = addr;
        expect_hit  = hit;
        expect_miss = miss;
        exp_rdata   = u_mem.read_word(addr);
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    exp_rdata[b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = data;
        req_wstrb = strb;
        while (!req_ready) begin
            @(posedge clk);
            #10;
        end
        @(posedge clk);
        #10;
        req_valid = 1'b0;
        rsp_ready = ($urandom_range(0, 2) != 0);
        while (!(rsp_valid && rsp_ready)) begin
            @(posedge clk);
            #10;
            rsp_ready = ($urandom_range(0, 2) != 0);
        end
        @(posedge clk);
        #10;
        rsp_ready = 1'b0;
        // the store counts as done once its response has transferred
        if (wr) begin
            u_mem.write_word(addr, exp_rdata);
            stale_line[addr[15:4]] = 1'b1;
        end
    endtask

    task automatic finish_run();
        $display("run ended after %0d cycles with %0d errors", cycles, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] set_addr [5];
        void'($urandom(2273));
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_wstrb   = '0;
        rsp_ready   = 1'b0;
        cur_addr    = '0;
        exp_rdata   = '0;
        expect_hit  = 1'b0;
        expect_miss = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(posedge clk);
        #10;
        // one line per set, so no eviction can happen here
        for (int s = 1; s <= 5; s++) begin
            addr = 32'h400 | (s << 4) | ($urandom_range(0, 3) << 2);
            issue_request(1'b0, addr, 1'b0, 1'b1);
            issue_request(1'b0, addr, 1'b1, 1'b0);
            issue_request(1'b1, addr, 1'b1, 1'b0);
            issue_request(1'b0, addr ^ 32'h4, 1'b1, 1'b0);
        end
        // five tags in set 40 against four ways
        for (int t = 0; t < 5; t++) begin
            set_addr[t] = ((t + 2) << 10) | (40 << 4) | ($urandom_range(0, 3) << 2);
            issue_request(t % 2 == 0, set_addr[t], 1'b0, 1'b1);
        end
        for (int t = 0; t < 15; t++) begin
            issue_request(t >= 5 && t < 10, set_addr[t % 5], 1'b0, 1'b0);
        end
        repeat (5) begin
            addr = $urandom_range(0, 16383) << 2;
            issue_request(1'($urandom_range(0, 1)), addr, 1'b0, 1'b0);
        end
        if (wb_bursts == 0) begin
            $display("no dirty line was ever written back, so the write-back checks never ran");
            err_count++;
        end
        finish_run();
    end

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        err_count++;
        finish_run();
    end

endmodule

//--- sim.f
+incdir+.
dcache_pkg.sv
lsu_port.sv
tag_array.sv
data_array.sv
cache_ctrl.sv
mem_burst.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - lsu_port.sv
      - tag_array.sv
      - data_array.sv
      - cache_ctrl.sv
      - mem_burst.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_model.sv
      - tb_dcache.sv
